/* common/mini_mcu_config.svh */
// memory map, bank size and bus data width of the mini mcu

`ifndef MINI_MCU_CONFIG_SVH
`define MINI_MCU_CONFIG_SVH

// bus
`define BUS_DATA_WIDTH 32

// one sram bank, in bytes
`define RAM_BANK_BYTES 32'd4096

// two sram banks, back to back
`define RAM0_START_ADDR 32'h0000_0000
`define RAM1_START_ADDR 32'h0000_1000

// soc control page
`define SOC_CTRL_START_ADDR 32'h2000_0000
`define SOC_CTRL_SIZE 32'h100

`endif

/* common/obi_pkg.sv */
// OBI request/response structs
// slave select and soc control register enums

`include "mini_mcu_config.svh"

package obi_pkg;

  // master to slave
  typedef struct packed {
    logic                         req;
    logic                         we;
    logic [`BUS_DATA_WIDTH/8-1:0] be;
    logic [31:0]                  addr;
    logic [`BUS_DATA_WIDTH-1:0]   wdata;
  } obi_req_t;

  // slave to master
  typedef struct packed {
    logic                       gnt;
    logic                       rvalid;
    logic                       err;
    logic [`BUS_DATA_WIDTH-1:0] rdata;
  } obi_resp_t;

  // address decode result
  typedef enum logic [1:0] {
    SLV_RAM0     = 2'd0,
    SLV_RAM1     = 2'd1,
    SLV_SOC_CTRL = 2'd2,
    SLV_NONE     = 2'd3
  } bus_slave_e;

  // word index inside the soc control page
  typedef enum logic [1:0] {
    REG_EXIT_VALID = 2'd0,
    REG_EXIT_VALUE = 2'd1,
    REG_BOOT_SEL   = 2'd2,
    REG_SCRATCH    = 2'd3
  } soc_ctrl_reg_e;

endpackage

/* memory_subsystem/obi_sram.sv */
// single-port byte-writable sram bank with an OBI slave port

`timescale 1ns/1ps
`include "mini_mcu_config.svh"

module obi_sram #(
  parameter int NUM_WORDS = 1024
) (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  obi_pkg::obi_req_t            req_i,
  output obi_pkg::obi_resp_t           resp_o,
  input  logic [$clog2(NUM_WORDS)-1:0] word_addr_i
);

  localparam int NUM_LANES = `BUS_DATA_WIDTH / 8;

  logic [`BUS_DATA_WIDTH-1:0] mem [NUM_WORDS];
  logic [`BUS_DATA_WIDTH-1:0] rdata_q;
  logic                       rvalid_q;

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      rdata_q <= mem[word_addr_i];
      if (req_i.we) begin
        for (int b = 0; b < NUM_LANES; b++) begin
          if (req_i.be[b]) begin
            mem[word_addr_i][8*b +: 8] <= req_i.wdata[8*b +: 8];
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
    end
  end

  // always ready
  assign resp_o.gnt    = req_i.req;
  assign resp_o.rvalid = rvalid_q;
  assign resp_o.err    = 1'b0;
  assign resp_o.rdata  = rdata_q;

endmodule

/* memory_subsystem/memory_subsystem.sv */
// memory subsystem with two sram banks
// bus address to bank word index

`timescale 1ns/1ps
`include "mini_mcu_config.svh"

module memory_subsystem (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  obi_pkg::obi_req_t  ram0_req_i,
  output obi_pkg::obi_resp_t ram0_resp_o,
  input  obi_pkg::obi_req_t  ram1_req_i,
  output obi_pkg::obi_resp_t ram1_resp_o
);

  localparam int BANK_WORDS = `RAM_BANK_BYTES / (`BUS_DATA_WIDTH / 8);
  localparam int WORD_AW = $clog2(BANK_WORDS);
  localparam int BYTE_OFS = $clog2(`BUS_DATA_WIDTH / 8);

  logic [31:0]        ram0_offset;
  logic [31:0]        ram1_offset;
  logic [WORD_AW-1:0] ram0_word;
  logic [WORD_AW-1:0] ram1_word;

  // strip base and byte offset
  assign ram0_offset = ram0_req_i.addr - `RAM0_START_ADDR;
  assign ram1_offset = ram1_req_i.addr - `RAM1_START_ADDR;
  assign ram0_word   = ram0_offset[WORD_AW+BYTE_OFS-1:BYTE_OFS];
  assign ram1_word   = ram1_offset[WORD_AW+BYTE_OFS-1:BYTE_OFS];

  obi_sram #(
    .NUM_WORDS(BANK_WORDS)
  ) ram0_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req_i      (ram0_req_i),
    .resp_o     (ram0_resp_o),
    .word_addr_i(ram0_word)
  );

  obi_sram #(
    .NUM_WORDS(BANK_WORDS)
  ) ram1_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req_i      (ram1_req_i),
    .resp_o     (ram1_resp_o),
    .word_addr_i(ram1_word)
  );

endmodule

/* system_bus/system_bus.sv */
// system bus: address decode, per-slave round-robin arbitration,
// response steering and error response for unmapped addresses

`timescale 1ns/1ps
`include "mini_mcu_config.svh"

module system_bus (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  obi_pkg::obi_req_t  core_instr_req_i,
  output obi_pkg::obi_resp_t core_instr_resp_o,
  input  obi_pkg::obi_req_t  core_data_req_i,
  output obi_pkg::obi_resp_t core_data_resp_o,
  output obi_pkg::obi_req_t  ram0_req_o,
  input  obi_pkg::obi_resp_t ram0_resp_i,
  output obi_pkg::obi_req_t  ram1_req_o,
  input  obi_pkg::obi_resp_t ram1_resp_i,
  output obi_pkg::obi_req_t  soc_ctrl_req_o,
  input  obi_pkg::obi_resp_t soc_ctrl_resp_i
);

  localparam int NUM_MST = 2;
  localparam int NUM_SLV = 3;
  localparam int M_INSTR = 0;
  localparam int M_DATA = 1;

  obi_pkg::obi_req_t               mst_req  [NUM_MST];
  obi_pkg::obi_resp_t              mst_resp [NUM_MST];
  obi_pkg::bus_slave_e             mst_dec  [NUM_MST];
  logic [NUM_MST-1:0]              mst_gnt;
  obi_pkg::obi_req_t               slv_req  [NUM_SLV];
  obi_pkg::obi_resp_t              slv_resp [NUM_SLV];
  logic [NUM_SLV-1:0][NUM_MST-1:0] slv_gnt;
  obi_pkg::bus_slave_e             owner_q  [NUM_MST];
  logic [NUM_MST-1:0]              pend_q;

  function automatic obi_pkg::bus_slave_e decode(input logic [31:0] addr);
    obi_pkg::bus_slave_e slv;
    slv = obi_pkg::SLV_NONE;
    if ((addr - `RAM0_START_ADDR) < `RAM_BANK_BYTES) begin
      slv = obi_pkg::SLV_RAM0;
    end else if ((addr - `RAM1_START_ADDR) < `RAM_BANK_BYTES) begin
      slv = obi_pkg::SLV_RAM1;
    end else if ((addr - `SOC_CTRL_START_ADDR) < `SOC_CTRL_SIZE) begin
      slv = obi_pkg::SLV_SOC_CTRL;
    end
    return slv;
  endfunction

  assign mst_req[M_INSTR]  = core_instr_req_i;
  assign mst_req[M_DATA]   = core_data_req_i;
  assign core_instr_resp_o = mst_resp[M_INSTR];
  assign core_data_resp_o  = mst_resp[M_DATA];

  assign ram0_req_o     = slv_req[obi_pkg::SLV_RAM0];
  assign ram1_req_o     = slv_req[obi_pkg::SLV_RAM1];
  assign soc_ctrl_req_o = slv_req[obi_pkg::SLV_SOC_CTRL];
  assign slv_resp[obi_pkg::SLV_RAM0]     = ram0_resp_i;
  assign slv_resp[obi_pkg::SLV_RAM1]     = ram1_resp_i;
  assign slv_resp[obi_pkg::SLV_SOC_CTRL] = soc_ctrl_resp_i;

  for (genvar m = 0; m < NUM_MST; m++) begin : g_dec
    assign mst_dec[m] = decode(mst_req[m].addr);
  end

  for (genvar s = 0; s < NUM_SLV; s++) begin : g_slv
    logic [NUM_MST-1:0] want;
    logic               win;
    logic               rr_q;

    for (genvar m = 0; m < NUM_MST; m++) begin : g_want
      assign want[m] = mst_req[m].req && (mst_dec[m] == obi_pkg::bus_slave_e'(s));
      assign slv_gnt[s][m] = want[m] && (win == 1'(m)) && slv_resp[s].gnt;
    end

    // rr_q holds the favored master when both ask
    assign win = (&want) ? rr_q : want[M_DATA];

    always_comb begin
      slv_req[s]     = mst_req[win];
      slv_req[s].req = |want;
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        rr_q <= 1'(M_DATA);
      end else if ((&want) && slv_resp[s].gnt) begin
        rr_q <= ~win;
      end
    end
  end

  // unmapped requests are granted at once
  always_comb begin
    for (int m = 0; m < NUM_MST; m++) begin
      mst_gnt[m] = 1'b0;
      for (int s = 0; s < NUM_SLV; s++) begin
        mst_gnt[m] = mst_gnt[m] | slv_gnt[s][m];
      end
      if (mst_dec[m] == obi_pkg::SLV_NONE) begin
        mst_gnt[m] = mst_req[m].req;
      end
    end
  end

  always_comb begin
    for (int m = 0; m < NUM_MST; m++) begin
      mst_resp[m]     = '0;
      mst_resp[m].gnt = mst_gnt[m];
      if (pend_q[m]) begin
        case (owner_q[m])
          obi_pkg::SLV_NONE: begin
            mst_resp[m].rvalid = 1'b1;
            mst_resp[m].err    = 1'b1;
          end
          default: begin
            mst_resp[m].rvalid = slv_resp[owner_q[m]].rvalid;
            mst_resp[m].err    = slv_resp[owner_q[m]].err;
            mst_resp[m].rdata  = slv_resp[owner_q[m]].rdata;
          end
        endcase
      end
    end
  end

  // which slave took each master's request last cycle
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int m = 0; m < NUM_MST; m++) begin
        pend_q[m]  <= 1'b0;
        owner_q[m] <= obi_pkg::SLV_NONE;
      end
    end else begin
      for (int m = 0; m < NUM_MST; m++) begin
        pend_q[m] <= mst_gnt[m];
        if (mst_gnt[m]) begin
          owner_q[m] <= mst_dec[m];
        end
      end
    end
  end

endmodule

/* hdl/soc_ctrl.sv */
// soc control registers: exit value/valid, boot select, scratch

`timescale 1ns/1ps
`include "mini_mcu_config.svh"

module soc_ctrl (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               boot_select_i,
  input  obi_pkg::obi_req_t  req_i,
  output obi_pkg::obi_resp_t resp_o,
  output logic [31:0]        exit_value_o,
  output logic               exit_valid_o
);

  localparam int OFS_W = $clog2(`SOC_CTRL_SIZE);
  localparam int NUM_LANES = `BUS_DATA_WIDTH / 8;

  logic [OFS_W-1:0]           ofs;
  logic                       reg_hit;
  obi_pkg::soc_ctrl_reg_e     reg_sel;
  logic [`BUS_DATA_WIDTH-1:0] rdata_d;
  logic [`BUS_DATA_WIDTH-1:0] rdata_q;
  logic                       rvalid_q;
  logic [`BUS_DATA_WIDTH-1:0] scratch_q;

  assign ofs     = req_i.addr[OFS_W-1:0];
  // only the first four words hold registers
  assign reg_hit = (ofs[OFS_W-1:4] == '0);
  assign reg_sel = obi_pkg::soc_ctrl_reg_e'(ofs[3:2]);

  always_comb begin
    rdata_d = '0;
    if (reg_hit) begin
      case (reg_sel)
        obi_pkg::REG_EXIT_VALID: rdata_d[0] = exit_valid_o;
        obi_pkg::REG_EXIT_VALUE: rdata_d = exit_value_o;
        obi_pkg::REG_BOOT_SEL:   rdata_d[0] = boot_select_i;
        default:                 rdata_d = scratch_q;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      exit_valid_o <= 1'b0;
      exit_value_o <= '0;
      scratch_q    <= '0;
      rvalid_q     <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
      if (req_i.req && req_i.we && reg_hit) begin
        case (reg_sel)
          obi_pkg::REG_EXIT_VALID: exit_valid_o <= req_i.wdata[0];
          obi_pkg::REG_EXIT_VALUE: exit_value_o <= req_i.wdata;
          obi_pkg::REG_SCRATCH: begin
            for (int b = 0; b < NUM_LANES; b++) begin
              if (req_i.be[b]) begin
                scratch_q[8*b +: 8] <= req_i.wdata[8*b +: 8];
              end
            end
          end
          // boot select is read only
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req && !req_i.we) begin
      rdata_q <= rdata_d;
    end
  end

  assign resp_o.gnt    = req_i.req;
  assign resp_o.rvalid = rvalid_q;
  assign resp_o.err    = 1'b0;
  assign resp_o.rdata  = rdata_q;

endmodule

/* hdl/core_v_mini_mcu.sv */
// mini mcu top: system bus, memory subsystem and soc control
// core instruction and data ports come from outside

`timescale 1ns/1ps

module core_v_mini_mcu (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               boot_select_i,
  input  obi_pkg::obi_req_t  core_instr_req_i,
  output obi_pkg::obi_resp_t core_instr_resp_o,
  input  obi_pkg::obi_req_t  core_data_req_i,
  output obi_pkg::obi_resp_t core_data_resp_o,
  output logic [31:0]        exit_value_o,
  output logic               exit_valid_o
);

  obi_pkg::obi_req_t  ram0_req;
  obi_pkg::obi_resp_t ram0_resp;
  obi_pkg::obi_req_t  ram1_req;
  obi_pkg::obi_resp_t ram1_resp;
  obi_pkg::obi_req_t  soc_ctrl_req;
  obi_pkg::obi_resp_t soc_ctrl_resp;

  system_bus system_bus_i (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .core_instr_req_i (core_instr_req_i),
    .core_instr_resp_o(core_instr_resp_o),
    .core_data_req_i  (core_data_req_i),
    .core_data_resp_o (core_data_resp_o),
    .ram0_req_o       (ram0_req),
    .ram0_resp_i      (ram0_resp),
    .ram1_req_o       (ram1_req),
    .ram1_resp_i      (ram1_resp),
    .soc_ctrl_req_o   (soc_ctrl_req),
    .soc_ctrl_resp_i  (soc_ctrl_resp)
  );

  memory_subsystem memory_subsystem_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .ram0_req_i (ram0_req),
    .ram0_resp_o(ram0_resp),
    .ram1_req_i (ram1_req),
    .ram1_resp_o(ram1_resp)
  );

  soc_ctrl soc_ctrl_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .boot_select_i(boot_select_i),
    .req_i        (soc_ctrl_req),
    .resp_o       (soc_ctrl_resp),
    .exit_value_o (exit_value_o),
    .exit_valid_o (exit_valid_o)
  );

endmodule

/* sim/tb_clk_gen.sv */
// testbench clock (10 ns period) and active-low reset for three cycles

`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (3) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

/* sim/tb_core_v_mini_mcu.sv */
// directed tests for the mini mcu fabric
// OBI bus tasks, compare tasks, byte-level RAM model and LCG

`timescale 1ns/1ps
`include "mini_mcu_config.svh"

module tb_core_v_mini_mcu;

  localparam bit PORT_INSTR = 1'b0;
  localparam bit PORT_DATA = 1'b1;
  localparam int TIMEOUT = 100;
  localparam logic [31:0] SOC = `SOC_CTRL_START_ADDR;

  logic               clk;
  logic               rst_n;
  logic               boot_select;
  obi_pkg::obi_req_t  instr_req;
  obi_pkg::obi_resp_t instr_resp;
  obi_pkg::obi_req_t  data_req;
  obi_pkg::obi_resp_t data_resp;
  logic [31:0]        exit_value;
  logic               exit_valid;

  logic [7:0]  ram_model [2*`RAM_BANK_BYTES];
  logic [31:0] lcg_state = 32'he5ca_eca8;
  int          errors = 0;
  int          stray_rvalid = 0;
  int          checks = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  bit          timed_out = 1'b0;
  bit          gnt_seen [2];

  tb_clk_gen i_clk_gen (
    .clk_o  (clk),
    .rst_n_o(rst_n)
  );

  core_v_mini_mcu i_dut (
    .clk_i            (clk),
    .rst_n_i          (rst_n),
    .boot_select_i    (boot_select),
    .core_instr_req_i (instr_req),
    .core_instr_resp_o(instr_resp),
    .core_data_req_i  (data_req),
    .core_data_resp_o (data_resp),
    .exit_value_o     (exit_value),
    .exit_valid_o     (exit_valid)
  );

  // an rvalid must follow a gnt one cycle earlier on the same port
  always @(negedge clk) begin
    if (rst_n) begin
      if (instr_resp.rvalid && !gnt_seen[0]) begin
        $display("instruction port gave rvalid without a gnt in the cycle before");
        stray_rvalid++;
      end
      if (data_resp.rvalid && !gnt_seen[1]) begin
        $display("data port gave rvalid without a gnt in the cycle before");
        stray_rvalid++;
      end
    end
    gnt_seen[0] = instr_resp.gnt;
    gnt_seen[1] = data_resp.gnt;
  end

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int error_count();
    return errors + stray_rvalid;
  endfunction

  task automatic model_write(input logic [31:0] addr, input logic [3:0] be,
                             input logic [31:0] data);
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        ram_model[{addr[12:2], 2'(b)}] = data[8*b +: 8];
      end
    end
  endtask

  function automatic logic [31:0] model_read(input logic [31:0] addr);
    logic [31:0] word;
    for (int b = 0; b < 4; b++) begin
      word[8*b +: 8] = ram_model[{addr[12:2], 2'(b)}];
    end
    return word;
  endfunction

  function automatic obi_pkg::obi_req_t build_req(input logic we, input logic [3:0] be,
                                                  input logic [31:0] addr,
                                                  input logic [31:0] wdata);
    obi_pkg::obi_req_t txn;
    txn.req   = 1'b1;
    txn.we    = we;
    txn.be    = be;
    txn.addr  = addr;
    txn.wdata = wdata;
    return txn;
  endfunction

  function automatic obi_pkg::obi_resp_t make_resp(input logic gnt, input logic rvalid,
                                                   input logic err, input logic [31:0] rdata);
    obi_pkg::obi_resp_t r;
    r.gnt    = gnt;
    r.rvalid = rvalid;
    r.err    = err;
    r.rdata  = rdata;
    return r;
  endfunction

  // gnt and rvalid only, rdata and err mean nothing without rvalid
  function automatic obi_pkg::obi_resp_t handshake_only(input obi_pkg::obi_resp_t r);
    return make_resp(r.gnt, r.rvalid, 1'b0, 32'h0);
  endfunction

  task automatic check_rdata(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      $display("CHECK FAILED %s: expected %08h, actual %08h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_resp(input string name, input obi_pkg::obi_resp_t exp,
                            input obi_pkg::obi_resp_t act);
    checks++;
    if (act !== exp) begin
      $display("CHECK FAILED %s: expected gnt %b rvalid %b err %b rdata %08h, %s",
               name, exp.gnt, exp.rvalid, exp.err, exp.rdata,
               $sformatf("actual gnt %b rvalid %b err %b rdata %08h",
                         act.gnt, act.rvalid, act.err, act.rdata));
      errors++;
    end
  endtask

  task automatic check_exit(input string name, input logic [31:0] exp_value,
                            input logic exp_valid);
    checks++;
    if (exit_value !== exp_value || exit_valid !== exp_valid) begin
      $display("CHECK FAILED %s: expected exit %08h valid %b, actual exit %08h valid %b",
               name, exp_value, exp_valid, exit_value, exit_valid);
      errors++;
    end
  endtask

  task automatic drive_port(input bit port, input obi_pkg::obi_req_t txn);
    if (port == PORT_DATA) begin
      data_req <= txn;
    end else begin
      instr_req <= txn;
    end
  endtask

  function automatic obi_pkg::obi_resp_t port_resp(input bit port);
    return (port == PORT_DATA) ? data_resp : instr_resp;
  endfunction

  // one OBI transfer; resp is sampled in the rvalid cycle
  task automatic bus_transfer(input bit port, input obi_pkg::obi_req_t txn,
                              output obi_pkg::obi_resp_t resp);
    int n;
    resp = '0;
    if (timed_out) return;
    @(posedge clk);
    drive_port(port, txn);
    n = 0;
    @(negedge clk);
    resp = port_resp(port);
    while (!resp.gnt && n < TIMEOUT) begin
      n++;
      @(negedge clk);
      resp = port_resp(port);
    end
    if (!resp.gnt) begin
      $display("timeout: no gnt on port %0d within %0d cycles", port, TIMEOUT);
      timed_out = 1'b1;
      errors++;
      return;
    end
    @(posedge clk);
    drive_port(port, '0);
    n = 0;
    @(negedge clk);
    resp = port_resp(port);
    while (!resp.rvalid && n < TIMEOUT) begin
      n++;
      @(negedge clk);
      resp = port_resp(port);
    end
    if (!resp.rvalid) begin
      $display("timeout: no rvalid on port %0d within %0d cycles", port, TIMEOUT);
      timed_out = 1'b1;
      errors++;
    end else if (n != 0) begin
      $display("rvalid on port %0d came %0d cycles later than one cycle after gnt", port, n);
      errors++;
    end
  endtask

  task automatic obi_write(input bit port, input logic [31:0] addr, input logic [3:0] be,
                           input logic [31:0] wdata, output obi_pkg::obi_resp_t resp);
    bus_transfer(port, build_req(1'b1, be, addr, wdata), resp);
  endtask

  task automatic obi_read(input bit port, input logic [31:0] addr,
                          output obi_pkg::obi_resp_t resp);
    bus_transfer(port, build_req(1'b0, 4'hf, addr, 32'h0), resp);
  endtask

  task automatic ram_write(input bit port, input logic [31:0] addr, input logic [3:0] be,
                           input logic [31:0] wdata);
    obi_pkg::obi_resp_t resp;
    obi_write(port, addr, be, wdata, resp);
    model_write(addr, be, wdata);
  endtask

  task automatic ram_read_check(input string name, input bit port, input logic [31:0] addr);
    obi_pkg::obi_resp_t resp;
    obi_read(port, addr, resp);
    check_rdata(name, model_read(addr), resp.rdata);
  endtask

  task automatic reg_read_check(input string name, input logic [31:0] addr,
                                input logic [31:0] exp);
    obi_pkg::obi_resp_t resp;
    obi_read(PORT_DATA, addr, resp);
    check_rdata(name, exp, resp.rdata);
  endtask

  // both ports ask for the same slave in the next cycle
  task automatic expect_winner(input string name, input bit data_wins);
    @(posedge clk);
    @(negedge clk);
    check_resp({name, " instr"}, make_resp(!data_wins, 1'b0, 1'b0, 32'h0),
               handshake_only(instr_resp));
    check_resp({name, " data"}, make_resp(data_wins, 1'b0, 1'b0, 32'h0),
               handshake_only(data_resp));
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests_run++;
    if (error_count() == errors_before) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, error_count() - errors_before);
      tests_failed++;
    end
  endtask

  function automatic logic [31:0] window_addr(input int idx);
    return ((idx < 32) ? `RAM0_START_ADDR : `RAM1_START_ADDR) + 32'(4 * (idx % 32));
  endfunction

  task automatic test_reset();
    int e;
    e = error_count();
    repeat (4) begin
      @(negedge clk);
      check_resp("test_reset instr idle", '0, handshake_only(instr_resp));
      check_resp("test_reset data idle", '0, handshake_only(data_resp));
    end
    check_exit("test_reset exit", 32'h0, 1'b0);
    finish_test("test_reset", e);
  endtask

  task automatic test_ram_byte_enables();
    int e;
    e = error_count();
    for (int i = 0; i < 4; i++) begin
      ram_write(PORT_DATA, `RAM0_START_ADDR + 32'h40 + 32'(4 * i), 4'hf, next_random());
      ram_write(PORT_DATA, `RAM1_START_ADDR + 32'h40 + 32'(4 * i), 4'hf, next_random());
    end
    for (int i = 0; i < 4; i++) begin
      ram_write(PORT_DATA, `RAM0_START_ADDR + 32'h40 + 32'(4 * i), 4'b0001 << i, next_random());
      ram_write(PORT_DATA, `RAM1_START_ADDR + 32'h40 + 32'(4 * i), 4'b1000 >> i, next_random());
    end
    for (int i = 0; i < 4; i++) begin
      ram_read_check("test_ram_byte_enables ram0", i[0], `RAM0_START_ADDR + 32'h40 + 32'(4 * i));
      ram_read_check("test_ram_byte_enables ram1", !i[0], `RAM1_START_ADDR + 32'h40 + 32'(4 * i));
    end
    finish_test("test_ram_byte_enables", e);
  endtask

  task automatic test_contention();
    int e;
    bit data_wins;
    e = error_count();
    // the pointer favors data after reset and flips on each contested grant
    data_wins = 1'b1;
    for (int i = 0; i < 8; i++) begin
      fork
        ram_write(PORT_INSTR, 32'h100 + 32'(4 * i), 4'hf, {16'h1a5a, 16'(i)});
        ram_write(PORT_DATA, 32'h180 + 32'(4 * i), 4'hf, {16'hd0d0, 16'(i)});
        expect_winner("test_contention winner", data_wins);
      join
      data_wins = !data_wins;
    end
    fork
      for (int i = 0; i < 8; i++) begin
        ram_read_check("test_contention instr", PORT_INSTR, 32'h100 + 32'(4 * i));
      end
      for (int i = 0; i < 8; i++) begin
        ram_read_check("test_contention data", PORT_DATA, 32'h180 + 32'(4 * i));
      end
    join
    // different banks are granted in the same cycle
    @(posedge clk);
    instr_req <= build_req(1'b0, 4'hf, `RAM0_START_ADDR + 32'h100, 32'h0);
    data_req  <= build_req(1'b0, 4'hf, `RAM1_START_ADDR + 32'h40, 32'h0);
    @(negedge clk);
    check_resp("test_contention instr gnt", make_resp(1'b1, 1'b0, 1'b0, 32'h0),
               handshake_only(instr_resp));
    check_resp("test_contention data gnt", make_resp(1'b1, 1'b0, 1'b0, 32'h0),
               handshake_only(data_resp));
    @(posedge clk);
    instr_req <= '0;
    data_req  <= '0;
    @(negedge clk);
    check_resp("test_contention instr rvalid",
               make_resp(1'b0, 1'b1, 1'b0, model_read(`RAM0_START_ADDR + 32'h100)), instr_resp);
    check_resp("test_contention data rvalid",
               make_resp(1'b0, 1'b1, 1'b0, model_read(`RAM1_START_ADDR + 32'h40)), data_resp);
    finish_test("test_contention", e);
  endtask

  task automatic test_soc_ctrl();
    int                 e;
    obi_pkg::obi_resp_t resp;
    e = error_count();
    obi_write(PORT_DATA, SOC + 32'hc, 4'hf, 32'h1234_5678, resp);
    reg_read_check("test_soc_ctrl scratch", SOC + 32'hc, 32'h1234_5678);
    obi_write(PORT_DATA, SOC + 32'hc, 4'b0100, 32'h00ab_0000, resp);
    reg_read_check("test_soc_ctrl scratch byte", SOC + 32'hc, 32'h12ab_5678);
    @(posedge clk);
    boot_select <= 1'b0;
    reg_read_check("test_soc_ctrl boot_sel 0", SOC + 32'h8, 32'h0);
    @(posedge clk);
    boot_select <= 1'b1;
    reg_read_check("test_soc_ctrl boot_sel 1", SOC + 32'h8, 32'h1);
    obi_write(PORT_DATA, SOC + 32'h8, 4'hf, 32'h0, resp);
    reg_read_check("test_soc_ctrl boot_sel write", SOC + 32'h8, 32'h1);
    obi_write(PORT_DATA, SOC + 32'h4, 4'b0001, 32'hcafe_0042, resp);
    check_exit("test_soc_ctrl exit value", 32'hcafe_0042, 1'b0);
    reg_read_check("test_soc_ctrl exit value read", SOC + 32'h4, 32'hcafe_0042);
    obi_write(PORT_DATA, SOC + 32'h0, 4'hf, 32'h1, resp);
    check_exit("test_soc_ctrl exit valid", 32'hcafe_0042, 1'b1);
    finish_test("test_soc_ctrl", e);
  endtask

  task automatic test_unmapped();
    int                 e;
    obi_pkg::obi_resp_t resp;
    e = error_count();
    ram_write(PORT_DATA, `RAM0_START_ADDR, 4'hf, 32'h0bad_f00d);
    obi_read(PORT_INSTR, SOC + `SOC_CTRL_SIZE, resp);
    check_resp("test_unmapped read", make_resp(1'b0, 1'b1, 1'b1, 32'h0), resp);
    // would alias ram0 word 0 if the decode ignored high bits
    obi_write(PORT_DATA, 32'h0000_2000, 4'hf, 32'hdead_beef, resp);
    check_resp("test_unmapped write", make_resp(1'b0, 1'b1, 1'b1, 32'h0), resp);
    ram_read_check("test_unmapped ram0", PORT_INSTR, `RAM0_START_ADDR);
    finish_test("test_unmapped", e);
  endtask

  task automatic test_random_traffic();
    int          e;
    logic [31:0] rnd;
    logic [31:0] addr;
    e = error_count();
    for (int i = 0; i < 64; i++) begin
      addr = window_addr(i);
      ram_write(PORT_DATA, addr, 4'hf, (addr * 32'h9e37_79b9) ^ 32'h5bd1_e995);
    end
    for (int i = 0; i < 200; i++) begin
      rnd  = next_random();
      addr = window_addr(int'(rnd[5:0]));
      if (rnd[6]) begin
        ram_write(rnd[7], addr, rnd[11:8], next_random());
      end else begin
        ram_read_check("test_random_traffic", rnd[7], addr);
      end
    end
    finish_test("test_random_traffic", e);
  endtask

  initial begin
    instr_req   <= '0;
    data_req    <= '0;
    boot_select <= 1'b0;
    repeat (5) @(posedge clk);
    test_reset();
    if (!timed_out) test_ram_byte_enables();
    if (!timed_out) test_contention();
    if (!timed_out) test_soc_ctrl();
    if (!timed_out) test_unmapped();
    if (!timed_out) test_random_traffic();
    $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, error_count());
    if (error_count() == 0 && !timed_out) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* tb.f */
+incdir+common
common/obi_pkg.sv
memory_subsystem/obi_sram.sv
memory_subsystem/memory_subsystem.sv
system_bus/system_bus.sv
hdl/soc_ctrl.sv
hdl/core_v_mini_mcu.sv
sim/tb_clk_gen.sv
sim/tb_core_v_mini_mcu.sv

/* Makefile */
SRCS := $(shell grep -v '^+' tb.f) common/mini_mcu_config.svh
BIN := obj_dir/Vtb_core_v_mini_mcu

all: run

$(BIN): tb.f $(SRCS)
	verilator --binary --timing --timescale 1ns/1ps -f tb.f \
		--top-module tb_core_v_mini_mcu -o Vtb_core_v_mini_mcu

run: $(BIN)
	./$(BIN) | tee sim.log
	@if grep -q "Finished with errors" sim.log; then exit 1; fi
	@grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
